// ==== verilog.f ====
+incdir+testbench
common/dsp_pkg.sv
hdl/dsp_regfile.sv
hdl/cmd_fifo.sv
dsp_core/dsp_alu.sv
dsp_core/dsp_exec.sv
hdl/dsp_ctrl_regs.sv
hdl/dsp_top.sv
testbench/tb_dsp_top.sv

// ==== Makefile ====
TOP = tb_dsp_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== testbench/tb_dsp_model.svh ====
`ifndef TB_DSP_MODEL_SVH
`define TB_DSP_MODEL_SVH

// Register contents as the host expects them, updated in command order.
logic [data_bits-1:0] model_regs [0:(1<<reg_addr_bits)-1];
logic [data_bits-1:0] expected_q [$];
logic                 model_sat = 1'b0;

function automatic logic [data_bits-1:0] model_alu(
	input dsp_op_e              op,
	input logic [data_bits-1:0] a,
	input logic [data_bits-1:0] b,
	input logic [imm_bits-1:0]  imm,
	input logic                 sat
);
	longint wide;
	int     pa;
	int     pb;
	wide = '0;
	pa = int'($signed(a[15:0]));
	pb = int'($signed(b[15:0]));
	case (op)
		OP_ADD: wide = longint'($signed(a)) + longint'($signed(b));
		OP_SUB: wide = longint'($signed(a)) - longint'($signed(b));
		OP_AND: return a & b;
		OP_OR:  return a | b;
		OP_XOR: return a ^ b;
		OP_MUL: return pa * pb;
		OP_LDI: return int'($signed(imm));
		default: return a;
	endcase
	// The exact sum is compared with the 32-bit signed range.
	if (sat && (wide > 64'sd2147483647)) begin
		return 32'h7fff_ffff;
	end
	if (sat && (wide < -64'sd2147483648)) begin
		return 32'h8000_0000;
	end
	return wide[31:0];
endfunction

function automatic void model_apply(
	input dsp_op_e                  op,
	input logic [reg_addr_bits-1:0] dst,
	input logic [reg_addr_bits-1:0] sa,
	input logic [reg_addr_bits-1:0] sb,
	input logic [imm_bits-1:0]      imm
);
	logic [data_bits-1:0] r;
	r = model_alu(op, model_regs[sa], model_regs[sb], imm, model_sat);
	if (op == OP_RD) begin
		expected_q.push_back(r);
	end else begin
		model_regs[dst] = r;
	end
endfunction

`endif

// ==== testbench/tb_dsp_top.sv ====
`timescale 1ns/1ps

module tb_dsp_top
	import dsp_pkg::*;
();

	localparam int total_cmds = 128 + 400 + 56 + 18 + 20;
	localparam int timeout_cycles = 20 * total_cmds + 200;

	logic                     sys_clk = 1'b0;
	logic                     arst_n;
	logic                     cmd_valid;
	dsp_op_e                  cmd_op;
	logic [reg_addr_bits-1:0] cmd_dst;
	logic [reg_addr_bits-1:0] cmd_src_a;
	logic [reg_addr_bits-1:0] cmd_src_b;
	logic [imm_bits-1:0]      cmd_imm;
	logic                     cmd_credit;
	logic                     res_valid;
	logic [data_bits-1:0]     res_data;
	logic                     res_credit;
	logic                     cfg_we;
	logic [cfg_addr_bits-1:0] cfg_addr;
	logic [data_bits-1:0]     cfg_wdata;
	logic [data_bits-1:0]     cfg_rdata;

	logic [31:0]          lfsr = 32'hd3c4_fc2e;
	logic [data_bits-1:0] exp_data;
	int cycle = 0;
	int errors = 0;
	int checked = 0;
	int sent = 0;
	int cmd_credits = cmd_fifo_depth;
	int outstanding = 0;
	int due_q [$];	// Cycle at which each result credit goes back.

	`include "tb_dsp_model.svh"

	dsp_top dut_i (.*);

	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle <= cycle + 1;
	end

	// Taps 32, 22, 2 and 1.
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	// Credits, results and the consumer are watched at the falling edge.
	always @(negedge sys_clk) begin
		if (arst_n) begin
			if (cmd_credit) begin
				cmd_credits++;
				if (cmd_credits > cmd_fifo_depth) begin
					$display("Command credit at %0t raised the count above the queue depth",
						$time);
					errors++;
				end
			end
			if (res_valid) begin
				if (expected_q.size() == 0) begin
					$display("Result %h at %0t arrived with no command waiting for it",
						res_data, $time);
					errors++;
				end else begin
					exp_data = expected_q.pop_front();
					checked++;
					if (res_data !== exp_data) begin
						$display("CHECK FAILED time=%0t signal=res_data got=%h expected=%h",
							$time, res_data, exp_data);
						errors++;
					end
				end
				outstanding++;
				if (outstanding > res_credits_init) begin
					$display("More results outstanding than result credits at %0t", $time);
					errors++;
				end
				due_q.push_back(cycle + int'(rand_bits(3)));
			end
		end
	end

	always @(posedge sys_clk) begin
		#10;
		res_credit = 1'b0;
		if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
			void'(due_q.pop_front());
			res_credit = 1'b1;
			outstanding--;
		end
	end

	task automatic step_cycle();
		@(posedge sys_clk);
		#10;
	endtask

	task automatic send_cmd(
		input dsp_op_e                  op,
		input logic [reg_addr_bits-1:0] dst,
		input logic [reg_addr_bits-1:0] sa,
		input logic [reg_addr_bits-1:0] sb,
		input logic [imm_bits-1:0]      imm
	);
		while (cmd_credits == 0) begin
			cmd_valid = 1'b0;
			step_cycle();
		end
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_dst = dst;
		cmd_src_a = sa;
		cmd_src_b = sb;
		cmd_imm = imm;
		cmd_credits--;
		sent++;
		model_apply(op, dst, sa, sb, imm);
		step_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic send_random_cmd();
		dsp_op_e                  op;
		logic [reg_addr_bits-1:0] dst;
		logic [reg_addr_bits-1:0] sa;
		logic [reg_addr_bits-1:0] sb;
		logic [imm_bits-1:0]      imm;
		op = dsp_op_e'(3'(rand_bits(3)));
		dst = reg_addr_bits'(rand_bits(reg_addr_bits));
		sa = reg_addr_bits'(rand_bits(reg_addr_bits));
		sb = reg_addr_bits'(rand_bits(reg_addr_bits));
		imm = imm_bits'(rand_bits(imm_bits));
		send_cmd(op, dst, sa, sb, imm);
	endtask

	// Returns once every command has left the queue and every result is consumed.
	task automatic drain();
		while ((cmd_credits != cmd_fifo_depth) || (expected_q.size() != 0) ||
			(outstanding != 0)) begin
			step_cycle();
		end
		repeat (4) step_cycle();
	endtask

	task automatic cfg_write(
		input logic [cfg_addr_bits-1:0] addr,
		input logic [data_bits-1:0]     data
	);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		if (addr == 1'b0) begin
			model_sat = data[0];
		end
		step_cycle();
		cfg_we = 1'b0;
	endtask

	task automatic forwarding_chains();
		logic [reg_addr_bits-1:0] prev;
		logic [reg_addr_bits-1:0] dst;
		dsp_op_e                  op;
		int c;
		int k;
		for (c = 0; c < 8; c++) begin
			prev = reg_addr_bits'(rand_bits(reg_addr_bits));
			for (k = 0; k < 6; k++) begin
				dst = reg_addr_bits'(rand_bits(reg_addr_bits));
				op = dsp_op_e'(3'(rand_bits(3)));
				if ((op == OP_RD) || (op == OP_LDI)) begin
					op = OP_SUB;	// Every link must read its sources.
				end
				if (k % 2 == 1) begin
					send_cmd(op, dst, prev, prev, '0);
				end else begin
					send_cmd(op, dst, prev, reg_addr_bits'(rand_bits(reg_addr_bits)), '0);
				end
				prev = dst;
			end
			send_cmd(OP_RD, '0, prev, '0, '0);
		end
	endtask

	task automatic saturation_run(input logic sat);
		logic [data_bits-1:0] exp_mode;
		exp_mode = '0;
		exp_mode[0] = sat;	// Only bit 0 of the mode word is defined.
		drain();
		cfg_write(1'b0, {{(data_bits-1){1'b0}}, sat});
		@(negedge sys_clk);
		if (cfg_rdata !== exp_mode) begin
			$display("CHECK FAILED time=%0t signal=cfg_rdata got=%h expected=%h",
				$time, cfg_rdata, exp_mode);
			errors++;
		end
		step_cycle();
		send_cmd(OP_LDI, 6'd1, '0, '0, 16'h7fff);
		send_cmd(OP_MUL, 6'd2, 6'd1, 6'd1, '0);	// 0x3fff0001.
		send_cmd(OP_ADD, 6'd3, 6'd2, 6'd2, '0);
		send_cmd(OP_ADD, 6'd4, 6'd3, 6'd3, '0);	// Positive overflow.
		send_cmd(OP_LDI, 6'd6, '0, '0, 16'h8000);
		send_cmd(OP_SUB, 6'd9, 6'd6, 6'd3, '0);
		send_cmd(OP_SUB, 6'd10, 6'd9, 6'd3, '0);	// Negative overflow.
		send_cmd(OP_RD, '0, 6'd4, '0, '0);
		send_cmd(OP_RD, '0, 6'd10, '0, '0);
		drain();
	endtask

	task automatic finish_run();
		$display("Commands sent: %0d, results checked: %0d, errors: %0d",
			sent, checked, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	initial begin
		int i;
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = OP_ADD;
		cmd_dst = '0;
		cmd_src_a = '0;
		cmd_src_b = '0;
		cmd_imm = '0;
		res_credit = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (16) @(posedge sys_clk);
		#10;
		arst_n = 1'b1;
		step_cycle();
		for (i = 0; i < 64; i++) begin
			send_cmd(OP_LDI, reg_addr_bits'(i), '0, '0, imm_bits'(rand_bits(imm_bits)));
		end
		for (i = 0; i < 64; i++) begin
			send_cmd(OP_RD, '0, reg_addr_bits'(i), '0, '0);
		end
		repeat (400) send_random_cmd();
		drain();
		forwarding_chains();
		saturation_run(1'b1);
		saturation_run(1'b0);
		cfg_write(1'b1, '0);
		repeat (20) send_random_cmd();
		drain();
		cfg_addr = 1'b1;
		@(negedge sys_clk);
		if (cfg_rdata !== 32'(20)) begin
			$display("CHECK FAILED time=%0t signal=cfg_rdata got=%0d expected=%0d",
				$time, cfg_rdata, 20);
			errors++;
		end
		step_cycle();
		finish_run();
	end

	initial begin
		while (cycle < timeout_cycles) begin
			@(posedge sys_clk);
		end
		$display("Timeout after %0d cycles, the DUT stopped returning credits or results",
			cycle);
		errors++;
		finish_run();
	end

endmodule

// ==== hdl/dsp_top.sv ====
`timescale 1ns/1ps

module dsp_top
	import dsp_pkg::*;
(
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic                     cmd_valid,
	input  dsp_op_e                  cmd_op,
	input  logic [reg_addr_bits-1:0] cmd_dst,
	input  logic [reg_addr_bits-1:0] cmd_src_a,
	input  logic [reg_addr_bits-1:0] cmd_src_b,
	input  logic [imm_bits-1:0]      cmd_imm,
	output logic                     cmd_credit,
	output logic                     res_valid,
	output logic [data_bits-1:0]     res_data,
	input  logic                     res_credit,
	input  logic                     cfg_we,
	input  logic [cfg_addr_bits-1:0] cfg_addr,
	input  logic [data_bits-1:0]     cfg_wdata,
	output logic [data_bits-1:0]     cfg_rdata
);

	logic                     empty;
	logic                     pop;
	dsp_op_e                  head_op;
	logic [reg_addr_bits-1:0] head_dst;
	logic [reg_addr_bits-1:0] head_src_a;
	logic [reg_addr_bits-1:0] head_src_b;
	logic [imm_bits-1:0]      head_imm;
	logic [reg_addr_bits-1:0] rd_addr_a;
	logic [reg_addr_bits-1:0] rd_addr_b;
	logic [reg_addr_bits-1:0] addr_a;
	logic [data_bits-1:0]     rdata_a;
	logic [data_bits-1:0]     rdata_b;
	logic                     we_a;
	logic [reg_addr_bits-1:0] wr_addr;
	logic [data_bits-1:0]     wdata;
	logic                     retire;
	logic                     sat_en;

	// Port A carries the write address when a write-back is due.
	assign addr_a = we_a ? wr_addr : rd_addr_a;

	cmd_fifo fifo_i (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.push       (cmd_valid),
		.push_op    (cmd_op),
		.push_dst   (cmd_dst),
		.push_src_a (cmd_src_a),
		.push_src_b (cmd_src_b),
		.push_imm   (cmd_imm),
		.pop        (pop),
		.empty      (empty),
		.head_op    (head_op),
		.head_dst   (head_dst),
		.head_src_a (head_src_a),
		.head_src_b (head_src_b),
		.head_imm   (head_imm),
		.credit     (cmd_credit)
	);

	dsp_exec exec_i (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.empty      (empty),
		.head_op    (head_op),
		.head_dst   (head_dst),
		.head_src_a (head_src_a),
		.head_src_b (head_src_b),
		.head_imm   (head_imm),
		.res_credit (res_credit),
		.sat_en     (sat_en),
		.pop        (pop),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rdata_a    (rdata_a),
		.rdata_b    (rdata_b),
		.we_a       (we_a),
		.wr_addr    (wr_addr),
		.wdata      (wdata),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.retire     (retire)
	);

	dsp_regfile regfile_i (
		.sys_clk (sys_clk),
		.we_a    (we_a),
		.addr_a  (addr_a),
		.wdata_a (wdata),
		.addr_b  (rd_addr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	dsp_ctrl_regs ctrl_i (
		.sys_clk   (sys_clk),
		.arst_n    (arst_n),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.retire    (retire),
		.sat_en    (sat_en)
	);

endmodule

// ==== hdl/dsp_ctrl_regs.sv ====
`timescale 1ns/1ps

module dsp_ctrl_regs
	import dsp_pkg::*;
(
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic                     cfg_we,
	input  logic [cfg_addr_bits-1:0] cfg_addr,
	input  logic [data_bits-1:0]     cfg_wdata,
	output logic [data_bits-1:0]     cfg_rdata,
	input  logic                     retire,
	output logic                     sat_en
);

	logic [data_bits-1:0] retired_cnt;
	logic                 cnt_sel;

	assign cnt_sel = (cfg_addr == cfg_addr_bits'(1));

	assign cfg_rdata = cnt_sel ? retired_cnt : {{(data_bits-1){1'b0}}, sat_en};

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sat_en <= 1'b0;
			retired_cnt <= '0;
		end else begin
			if (cfg_we && !cnt_sel) begin
				sat_en <= cfg_wdata[0];
			end
			if (retire) begin
				retired_cnt <= retired_cnt + 1'b1;	// Takes priority over a clear.
			end else if (cfg_we && cnt_sel) begin
				retired_cnt <= '0;
			end
		end
	end

endmodule

// ==== dsp_core/dsp_exec.sv ====
`timescale 1ns/1ps

module dsp_exec
	import dsp_pkg::*;
(
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic                     empty,
	input  dsp_op_e                  head_op,
	input  logic [reg_addr_bits-1:0] head_dst,
	input  logic [reg_addr_bits-1:0] head_src_a,
	input  logic [reg_addr_bits-1:0] head_src_b,
	input  logic [imm_bits-1:0]      head_imm,
	input  logic                     res_credit,
	input  logic                     sat_en,
	output logic                     pop,
	output logic [reg_addr_bits-1:0] rd_addr_a,
	output logic [reg_addr_bits-1:0] rd_addr_b,
	input  logic [data_bits-1:0]     rdata_a,
	input  logic [data_bits-1:0]     rdata_b,
	output logic                     we_a,
	output logic [reg_addr_bits-1:0] wr_addr,
	output logic [data_bits-1:0]     wdata,
	output logic                     res_valid,
	output logic [data_bits-1:0]     res_data,
	output logic                     retire
);

	logic                     s2_valid;
	dsp_op_e                  s2_op;
	logic [reg_addr_bits-1:0] s2_dst;
	logic [reg_addr_bits-1:0] s2_src_a;
	logic [reg_addr_bits-1:0] s2_src_b;
	logic [imm_bits-1:0]      s2_imm;
	logic                     wb_valid;
	logic [reg_addr_bits-1:0] wb_addr;
	logic [data_bits-1:0]     wb_data;
	logic [res_cnt_bits-1:0]  res_cnt;
	logic                     rd_block;
	logic                     issue_rd;
	logic [data_bits-1:0]     opnd_a;
	logic [data_bits-1:0]     opnd_b;
	logic [data_bits-1:0]     alu_result;

	// Port A address is needed for the write in t+1, so no issue then.
	assign we_a = s2_valid && (s2_op != OP_RD);
	assign rd_block = (head_op == OP_RD) && (res_cnt == '0);
	assign pop = !empty && !we_a && !rd_block;
	assign issue_rd = pop && (head_op == OP_RD);

	assign rd_addr_a = head_src_a;
	assign rd_addr_b = head_src_b;

	assign opnd_a = (wb_valid && (wb_addr == s2_src_a)) ? wb_data : rdata_a;
	assign opnd_b = (wb_valid && (wb_addr == s2_src_b)) ? wb_data : rdata_b;

	dsp_alu alu_i (
		.op     (s2_op),
		.a      (opnd_a),
		.b      (opnd_b),
		.imm    (s2_imm),
		.sat_en (sat_en),
		.result (alu_result)
	);

	assign wr_addr = s2_dst;
	assign wdata = alu_result;
	assign retire = s2_valid;

	always_ff @(posedge sys_clk) begin
		s2_op <= head_op;
		s2_dst <= head_dst;
		s2_src_a <= head_src_a;
		s2_src_b <= head_src_b;
		s2_imm <= head_imm;
		res_data <= alu_result;
		if (we_a) begin
			wb_addr <= s2_dst;
			wb_data <= alu_result;
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_valid <= 1'b0;
			wb_valid <= 1'b0;
			res_valid <= 1'b0;
			res_cnt <= res_cnt_bits'(res_credits_init);
		end else begin
			s2_valid <= pop;
			res_valid <= s2_valid && (s2_op == OP_RD);
			if (we_a) begin
				wb_valid <= 1'b1;	// Holds the last write from then on.
			end
			case ({res_credit, issue_rd})
				2'b10: res_cnt <= res_cnt + 1'b1;
				2'b01: res_cnt <= res_cnt - 1'b1;
				default: res_cnt <= res_cnt;
			endcase
		end
	end

	// A consumer returning more credits than it was given is a protocol error.
	assert property (@(posedge sys_clk) disable iff (!arst_n)
		res_cnt <= res_cnt_bits'(res_credits_init))
		else $error("dsp_exec result credits above initial count");

endmodule

// ==== dsp_core/dsp_alu.sv ====
`timescale 1ns/1ps

module dsp_alu
	import dsp_pkg::*;
(
	input  dsp_op_e              op,
	input  logic [data_bits-1:0] a,
	input  logic [data_bits-1:0] b,
	input  logic [imm_bits-1:0]  imm,
	input  logic                 sat_en,
	output logic [data_bits-1:0] result
);

	localparam int half_bits = data_bits / 2;

	logic [data_bits-1:0] sum;
	logic [data_bits-1:0] diff;
	logic [data_bits-1:0] product;
	logic [data_bits-1:0] clamp;
	logic                 sum_ovf;
	logic                 diff_ovf;

	assign sum = a + b;
	assign diff = a - b;
	assign product = $signed(a[half_bits-1:0]) * $signed(b[half_bits-1:0]);

	// Overflow shows as a result sign that the operand signs cannot produce.
	assign sum_ovf = (a[data_bits-1] == b[data_bits-1]) &&
		(sum[data_bits-1] != a[data_bits-1]);
	assign diff_ovf = (a[data_bits-1] != b[data_bits-1]) &&
		(diff[data_bits-1] != a[data_bits-1]);

	// Both overflow kinds clamp toward the sign of operand a.
	assign clamp = a[data_bits-1] ? {1'b1, {(data_bits-1){1'b0}}} :
		{1'b0, {(data_bits-1){1'b1}}};

	always_comb begin
		case (op)
			OP_ADD: result = (sat_en && sum_ovf) ? clamp : sum;
			OP_SUB: result = (sat_en && diff_ovf) ? clamp : diff;
			OP_AND: result = a & b;
			OP_OR:  result = a | b;
			OP_XOR: result = a ^ b;
			OP_MUL: result = product;
			OP_LDI: result = {{(data_bits-imm_bits){imm[imm_bits-1]}}, imm};
			OP_RD:  result = a;
			default: result = a;
		endcase
	end

endmodule

// ==== hdl/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo
	import dsp_pkg::*;
(
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic                     push,
	input  dsp_op_e                  push_op,
	input  logic [reg_addr_bits-1:0] push_dst,
	input  logic [reg_addr_bits-1:0] push_src_a,
	input  logic [reg_addr_bits-1:0] push_src_b,
	input  logic [imm_bits-1:0]      push_imm,
	input  logic                     pop,
	output logic                     empty,
	output dsp_op_e                  head_op,
	output logic [reg_addr_bits-1:0] head_dst,
	output logic [reg_addr_bits-1:0] head_src_a,
	output logic [reg_addr_bits-1:0] head_src_b,
	output logic [imm_bits-1:0]      head_imm,
	output logic                     credit
);

	dsp_op_e                  op_mem    [0:cmd_fifo_depth-1];
	logic [reg_addr_bits-1:0] dst_mem   [0:cmd_fifo_depth-1];
	logic [reg_addr_bits-1:0] src_a_mem [0:cmd_fifo_depth-1];
	logic [reg_addr_bits-1:0] src_b_mem [0:cmd_fifo_depth-1];
	logic [imm_bits-1:0]      imm_mem   [0:cmd_fifo_depth-1];

	logic [fifo_ptr_bits-1:0] wr_ptr;
	logic [fifo_ptr_bits-1:0] rd_ptr;
	logic [fifo_cnt_bits-1:0] count;
	logic                     full;

	assign empty = (count == '0);
	assign full = (count == fifo_cnt_bits'(cmd_fifo_depth));

	// The head is read straight from the array so a fresh entry pops next cycle.
	assign head_op = op_mem[rd_ptr];
	assign head_dst = dst_mem[rd_ptr];
	assign head_src_a = src_a_mem[rd_ptr];
	assign head_src_b = src_b_mem[rd_ptr];
	assign head_imm = imm_mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (push) begin
			op_mem[wr_ptr] <= push_op;
			dst_mem[wr_ptr] <= push_dst;
			src_a_mem[wr_ptr] <= push_src_a;
			src_b_mem[wr_ptr] <= push_src_b;
			imm_mem[wr_ptr] <= push_imm;
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + fifo_cnt_bits'(push) - fifo_cnt_bits'(pop);
			credit <= pop;	// One credit back per entry taken.
		end
	end

	// A host that respects its credits can never find the queue full.
	assert property (@(posedge sys_clk) disable iff (!arst_n) !(push && full))
		else $error("cmd_fifo push while full");

endmodule

// ==== hdl/dsp_regfile.sv ====
`timescale 1ns/1ps

module dsp_regfile
	import dsp_pkg::*;
(
	input  logic                     sys_clk,
	input  logic                     we_a,
	input  logic [reg_addr_bits-1:0] addr_a,
	input  logic [data_bits-1:0]     wdata_a,
	input  logic [reg_addr_bits-1:0] addr_b,
	output logic [data_bits-1:0]     rdata_a,
	output logic [data_bits-1:0]     rdata_b
);

	logic [data_bits-1:0] mem [0:(1<<reg_addr_bits)-1];

	// Both ports are read on every edge. The nonblocking write means a read
	// of the address being written on the same edge sees the old word.
	always_ff @(posedge sys_clk) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end
		rdata_a <= mem[addr_a];
		rdata_b <= mem[addr_b];
	end

endmodule

// ==== common/dsp_pkg.sv ====
package dsp_pkg;

	// Register file geometry.
	localparam int reg_addr_bits = 6;
	localparam int data_bits = 32;
	localparam int imm_bits = 16;

	// Command queue sizes, the depth is also the host's starting credit count.
	localparam int cmd_fifo_depth = 4;
	localparam int fifo_ptr_bits = 2;
	localparam int fifo_cnt_bits = 3;

	// Result channel credits held by the unit after reset.
	localparam int res_credits_init = 2;
	localparam int res_cnt_bits = 2;

	// Configuration space has two words, mode at 0 and retired count at 1.
	localparam int cfg_addr_bits = 1;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,	// May saturate.
		OP_SUB = 3'd1,	// May saturate.
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_MUL = 3'd5,	// Signed low halves.
		OP_LDI = 3'd6,	// Sign-extended immediate.
		OP_RD  = 3'd7	// Source A goes out on the result channel.
	} dsp_op_e;

endpackage
